// ==== project.f ====
logic/core_pkg.sv
logic/register_file.sv
logic/decode_unit.sv
logic/execute_unit.sv
logic/fetch_unit.sv
logic/load_store_unit.sv
logic/core_top.sv
tests/mem_model.sv
tests/tb_core.sv

// ==== tests/tb_core.sv ====
module tb_core;
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	localparam logic [31:0] err_base = 32'h0000_1000;

	logic clock, rst_n;
	logic imem_req_valid, imem_req_ready, imem_rsp_valid, imem_rsp_ready;
	logic dmem_req_valid, dmem_req_ready, dmem_rsp_valid, dmem_rsp_ready;
	mem_req_t imem_req, dmem_req;
	mem_rsp_t imem_rsp, dmem_rsp;
	logic retire_valid;
	logic [31:0] retire_pc;

	logic [31:0] retire_q[$];
	logic [63:0] store_q[$]; // {addr, data}.
	int passes, fails, cycles, limit, load_idx;
	int errs[6];
	string names[6] = '{"reset", "retire order", "arithmetic stores", "load round trip",
		"handshake stability", "error recovery"};
	logic done, timed_out, first_req, err_pending, recovered;

	core_top DUT (.*);

	mem_model u_mem (.*);

	function automatic logic [31:0] r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
		logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'h33};
	endfunction

	function automatic logic [31:0] i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
		logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] store_word(logic [4:0] src, logic [11:0] off);
		return {off[11:5], src, 5'd0, 3'b010, off[4:0], 7'h23}; // base is x0.
	endfunction

	function automatic logic [31:0] b_type(logic [12:0] imm, logic [4:0] rs1, logic [4:0] rs2,
		logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
	endfunction

	function automatic logic [31:0] j_type(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
	endfunction

	task automatic put(input logic [31:0] word);
		u_mem.words[load_idx] = word;
		load_idx++;
	endtask

	task automatic check_value(input int t, input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) passes++;
		else begin
			fails++;
			errs[t]++;
			$display("mismatch %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic load_program();
		for (int i = 0; i < 1024; i++)
			u_mem.words[i] = 32'ha5a5_0000 | (i << 2);
		u_mem.words[32'h200 >> 2] = 32'h0000_0041;
		load_idx = 0;
		put({20'h12345, 5'd1, 7'h37}); // lui x1.
		put(i_type(12'd5, 0, 3'b000, 2, 7'h13));
		put(i_type(12'hffd, 0, 3'b000, 3, 7'h13)); // x3 = -3.
		put(r_type(7'h00, 3, 2, 3'b000, 4));
		put(r_type(7'h20, 3, 2, 3'b000, 5));
		put(r_type(7'h00, 2, 3, 3'b010, 6));
		put(r_type(7'h00, 2, 1, 3'b100, 7));
		put(r_type(7'h00, 5, 4, 3'b110, 8));
		put(r_type(7'h00, 5, 3, 3'b111, 9));
		put({20'h00001, 5'd10, 7'h17}); // auipc at 0x24.
		put(i_type(12'h0ff, 2, 3'b100, 11, 7'h13));
		put(i_type(12'h00f, 3, 3'b111, 12, 7'h13));
		put(i_type(12'd7, 0, 3'b000, 0, 7'h13)); // write to x0 is dropped.
		for (int r = 4; r <= 12; r++)
			put(store_word(5'(r), 12'(32'h100 + (r - 4) * 4)));
		put(store_word(0, 12'h124));
		put(i_type(12'h200, 0, 3'b010, 13, 7'h03));
		put(i_type(12'd1, 13, 3'b000, 13, 7'h13));
		put(store_word(13, 12'h204));
		put(b_type(13'd8, 2, 3, 3'b000)); // 0x68
		put(b_type(13'd8, 2, 2, 3'b000));
		put(i_type(12'd1, 0, 3'b000, 15, 7'h13));
		put(b_type(13'd8, 2, 2, 3'b001));
		put(b_type(13'd8, 2, 3, 3'b001));
		put(i_type(12'd1, 0, 3'b000, 15, 7'h13));
		put(b_type(13'd8, 2, 3, 3'b100));
		put(b_type(13'd8, 3, 2, 3'b100));
		put(i_type(12'd1, 0, 3'b000, 15, 7'h13));
		put(b_type(13'd8, 3, 2, 3'b101));
		put(b_type(13'd8, 2, 3, 3'b101));
		put(i_type(12'd1, 0, 3'b000, 15, 7'h13));
		put(j_type(21'd8, 1)); // 0x98
		put(i_type(12'd1, 0, 3'b000, 15, 7'h13));
		put(i_type(12'd12, 1, 3'b000, 14, 7'h67)); // jalr to 0xa8.
		put(i_type(12'd1, 0, 3'b000, 15, 7'h13));
		put(store_word(14, 12'h208));
		put(store_word(15, 12'h20c)); // skipped addi must not have run.
		put({20'h00002, 5'd15, 7'h37});
		put(i_type(12'd0, 15, 3'b000, 0, 7'h67)); // jump into the fault range.
	endtask

	task automatic build_expected();
		for (int a = 0; a <= 32'h6c; a += 4)
			retire_q.push_back(a);
		retire_q.push_back(32'h74);
		retire_q.push_back(32'h78);
		retire_q.push_back(32'h80);
		retire_q.push_back(32'h84);
		retire_q.push_back(32'h8c);
		retire_q.push_back(32'h90);
		retire_q.push_back(32'h98);
		retire_q.push_back(32'ha0);
		retire_q.push_back(32'ha8);
		retire_q.push_back(32'hac);
		retire_q.push_back(32'hb0);
		retire_q.push_back(32'hb4);
		for (int a = 0; a <= 32'h34; a += 4)
			retire_q.push_back(a);
		store_q = '{{32'h100, 32'h2}, {32'h104, 32'h8}, {32'h108, 32'h1},
			{32'h10c, 32'h1234_5005}, {32'h110, 32'ha}, {32'h114, 32'h8},
			{32'h118, 32'h1024}, {32'h11c, 32'hfa}, {32'h120, 32'hd}, {32'h124, 32'h0},
			{32'h204, 32'h42}, {32'h208, 32'ha4}, {32'h20c, 32'h0}, {32'h100, 32'h2}};
		limit = 40 * retire_q.size();
	endtask

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	assert property (@(posedge clock) !rst_n |-> !imem_req_valid && !dmem_req_valid &&
		!imem_rsp_ready && !dmem_rsp_ready && !retire_valid) passes++;
	else begin
		fails++;
		errs[0]++;
		$display("core output active during reset");
	end

	assert property (@(posedge clock) disable iff (!rst_n)
		imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req)) passes++;
	else begin
		fails++;
		errs[4]++;
		$display("instruction request dropped or changed before it was accepted");
	end

	assert property (@(posedge clock) disable iff (!rst_n)
		dmem_req_valid && !dmem_req_ready |=> dmem_req_valid && $stable(dmem_req)) passes++;
	else begin
		fails++;
		errs[4]++;
		$display("data request dropped or changed before it was accepted");
	end

	always @(posedge clock) begin
		if (rst_n && !done && !timed_out) begin
			cycles++;
			if (imem_req_valid && imem_req_ready) begin
				if (first_req) begin
					check_value(0, "imem_req.addr", 32'h0, imem_req.addr);
					first_req = 1'b0;
					$display("test %s finished with %0d errors", names[0], errs[0]);
				end
				if (err_pending) begin
					check_value(5, "imem_req.addr", 32'h0, imem_req.addr);
					err_pending = 1'b0;
					recovered = 1'b1;
				end
				if (imem_req.addr >= err_base)
					err_pending = 1'b1;
			end
			if (retire_valid) begin
				if (err_pending) begin
					fails++;
					errs[5]++;
					$display("instruction retired after a failed fetch");
				end
				if (retire_q.size() == 0) begin
					fails++;
					errs[1]++;
					$display("retire seen after the expected trace ended");
				end else begin
					check_value(1, "retire_pc", retire_q.pop_front(), retire_pc);
					if (retire_q.size() == 0)
						done = 1'b1;
				end
			end
			if (dmem_req_valid && dmem_req_ready) begin
				if (!dmem_req.write) begin
					check_value(3, "dmem_req.addr", 32'h200, dmem_req.addr);
				end else if (store_q.size() == 0) begin
					fails++;
					errs[2]++;
					$display("unexpected store to %h", dmem_req.addr);
				end else begin
					logic [63:0] exp_store;
					int t;
					exp_store = store_q.pop_front();
					t = (exp_store[63:32] == 32'h204) ? 3 : 2;
					check_value(t, "dmem_req.addr", exp_store[63:32], dmem_req.addr);
					check_value(t, "dmem_req.wdata", exp_store[31:0], dmem_req.wdata);
					check_value(t, "dmem_req.wstrb", 32'hf, 32'(dmem_req.wstrb));
				end
			end
			if (cycles >= limit)
				timed_out = 1'b1;
		end
	end

	initial begin
		void'($urandom(32'hc20c8541));
		rst_n = 1'b0;
		passes = 0;
		fails = 0;
		cycles = 0;
		done = 1'b0;
		timed_out = 1'b0;
		first_req = 1'b1;
		err_pending = 1'b0;
		recovered = 1'b0;
		load_program();
		build_expected();
		repeat (4) @(posedge clock);
		rst_n <= 1'b1;
		wait (done || timed_out);
		if (timed_out) begin
			fails++;
			$display("timeout after %0d cycles, %0d retires missing", cycles, retire_q.size());
		end
		if (!recovered) begin
			fails++;
			errs[5]++;
			$display("no refetch from address 0 after the fetch error");
		end
		if (store_q.size() != 0) begin
			fails++;
			errs[2]++;
			$display("%0d expected stores never issued", store_q.size());
		end
		for (int t = 1; t < 6; t++)
			$display("test %s finished with %0d errors", names[t], errs[t]);
		$display("checks passed %0d failed %0d", passes, fails);
		if (fails == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== tests/mem_model.sv ====
module mem_model (
	input  logic clock,
	input  logic rst_n,
	input  logic imem_req_valid,
	output logic imem_req_ready,
	input  core_pkg::mem_req_t imem_req,
	output logic imem_rsp_valid,
	input  logic imem_rsp_ready,
	output core_pkg::mem_rsp_t imem_rsp,
	input  logic dmem_req_valid,
	output logic dmem_req_ready,
	input  core_pkg::mem_req_t dmem_req,
	output logic dmem_rsp_valid,
	input  logic dmem_rsp_ready,
	output core_pkg::mem_rsp_t dmem_rsp
);
	timeunit 1ns;
	timeprecision 1ps;
	import core_pkg::*;

	localparam logic [31:0] err_base = 32'h0000_1000;

	logic [31:0] words [0:1023];
	logic i_busy, d_busy;
	logic [1:0] i_ready_lat, i_rsp_lat, d_ready_lat, d_rsp_lat;

	// one word access, anything from err_base up faults.
	function automatic mem_rsp_t access(mem_req_t r);
		mem_rsp_t rsp;
		rsp.err = (r.addr >= err_base);
		rsp.rdata = '0;
		if (!rsp.err) begin
			if (r.write) begin
				for (int b = 0; b < 4; b++)
					if (r.wstrb[b])
						words[r.addr[11:2]][8*b +: 8] = r.wdata[8*b +: 8];
			end else begin
				rsp.rdata = words[r.addr[11:2]];
			end
		end
		return rsp;
	endfunction

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			imem_req_ready <= 1'b0;
			imem_rsp_valid <= 1'b0;
			imem_rsp <= '0;
			i_busy <= 1'b0;
			i_ready_lat <= 2'd0;
			i_rsp_lat <= 2'd0;
		end else begin
			if (imem_rsp_valid && imem_rsp_ready) begin
				imem_rsp_valid <= 1'b0;
				i_busy <= 1'b0;
			end
			if (!i_busy) begin
				if (imem_req_valid && imem_req_ready) begin
					imem_req_ready <= 1'b0;
					i_busy <= 1'b1;
					i_rsp_lat <= 2'($urandom_range(0, 3));
					i_ready_lat <= 2'($urandom_range(0, 3));
					imem_rsp <= access(imem_req);
				end else if (imem_req_valid) begin
					if (i_ready_lat == 0)
						imem_req_ready <= 1'b1;
					else
						i_ready_lat <= i_ready_lat - 1'b1;
				end
			end else if (!imem_rsp_valid) begin
				if (i_rsp_lat == 0)
					imem_rsp_valid <= 1'b1; // response may still be held off by the core.
				else
					i_rsp_lat <= i_rsp_lat - 1'b1;
			end
		end
	end

	always @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			dmem_req_ready <= 1'b0;
			dmem_rsp_valid <= 1'b0;
			dmem_rsp <= '0;
			d_busy <= 1'b0;
			d_ready_lat <= 2'd0;
			d_rsp_lat <= 2'd0;
		end else begin
			if (dmem_rsp_valid && dmem_rsp_ready) begin
				dmem_rsp_valid <= 1'b0;
				d_busy <= 1'b0;
			end
			if (!d_busy) begin
				if (dmem_req_valid && dmem_req_ready) begin
					dmem_req_ready <= 1'b0;
					d_busy <= 1'b1;
					d_rsp_lat <= 2'($urandom_range(0, 3));
					d_ready_lat <= 2'($urandom_range(0, 3));
					dmem_rsp <= access(dmem_req);
				end else if (dmem_req_valid) begin
					if (d_ready_lat == 0)
						dmem_req_ready <= 1'b1;
					else
						d_ready_lat <= d_ready_lat - 1'b1;
				end
			end else if (!dmem_rsp_valid) begin
				if (d_rsp_lat == 0)
					dmem_rsp_valid <= 1'b1;
				else
					d_rsp_lat <= d_rsp_lat - 1'b1;
			end
		end
	end

endmodule

// ==== logic/core_top.sv ====
module core_top (
	input  logic clock,
	input  logic rst_n,

	output logic imem_req_valid,
	input  logic imem_req_ready,
	output core_pkg::mem_req_t imem_req,
	input  logic imem_rsp_valid,
	output logic imem_rsp_ready,
	input  core_pkg::mem_rsp_t imem_rsp,

	output logic dmem_req_valid,
	input  logic dmem_req_ready,
	output core_pkg::mem_req_t dmem_req,
	input  logic dmem_rsp_valid,
	output logic dmem_rsp_ready,
	input  core_pkg::mem_rsp_t dmem_rsp,

	output logic retire_valid,
	output logic [core_pkg::xlen-1:0] retire_pc
);
	import core_pkg::*;

	logic [xlen-1:0] pc;
	logic [31:0] inst;
	logic inst_valid;
	decoded_t decoded;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;
	logic [xlen-1:0] alu_result;
	logic [xlen-1:0] next_pc;
	logic retire;
	logic wb_en;
	logic [reg_addr_w-1:0] wb_rd;
	logic [xlen-1:0] wb_data;
	logic data_err;

	fetch_unit u_fetch (
		.clock(clock),
		.rst_n(rst_n),
		.imem_req_valid(imem_req_valid),
		.imem_req_ready(imem_req_ready),
		.imem_req(imem_req),
		.imem_rsp_valid(imem_rsp_valid),
		.imem_rsp_ready(imem_rsp_ready),
		.imem_rsp(imem_rsp),
		.retire(retire),
		.next_pc(next_pc),
		.data_err(data_err),
		.pc(pc),
		.inst(inst),
		.inst_valid(inst_valid)
	);

	decode_unit u_decode (
		.inst(inst),
		.decoded(decoded)
	);

	register_file u_regs (
		.clock(clock),
		.rst_n(rst_n),
		.rs1(decoded.rs1),
		.rs2(decoded.rs2),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	execute_unit u_execute (
		.pc(pc),
		.decoded(decoded),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.alu_result(alu_result),
		.next_pc(next_pc)
	);

	load_store_unit u_lsu (
		.clock(clock),
		.rst_n(rst_n),
		.inst_valid(inst_valid),
		.pc(pc),
		.decoded(decoded),
		.alu_result(alu_result),
		.rs2_data(rs2_data),
		.dmem_req_valid(dmem_req_valid),
		.dmem_req_ready(dmem_req_ready),
		.dmem_req(dmem_req),
		.dmem_rsp_valid(dmem_rsp_valid),
		.dmem_rsp_ready(dmem_rsp_ready),
		.dmem_rsp(dmem_rsp),
		.retire(retire),
		.wb_en(wb_en),
		.wb_rd(wb_rd),
		.wb_data(wb_data),
		.data_err(data_err),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc)
	);

endmodule

// ==== logic/load_store_unit.sv ====
module load_store_unit (
	input  logic clock,
	input  logic rst_n,
	input  logic inst_valid,
	input  logic [core_pkg::xlen-1:0] pc,
	input  core_pkg::decoded_t decoded,
	input  logic [core_pkg::xlen-1:0] alu_result,
	input  logic [core_pkg::xlen-1:0] rs2_data,
	output logic dmem_req_valid,
	input  logic dmem_req_ready,
	output core_pkg::mem_req_t dmem_req,
	input  logic dmem_rsp_valid,
	output logic dmem_rsp_ready,
	input  core_pkg::mem_rsp_t dmem_rsp,
	output logic retire,
	output logic wb_en,
	output logic [core_pkg::reg_addr_w-1:0] wb_rd,
	output logic [core_pkg::xlen-1:0] wb_data,
	output logic data_err,
	output logic retire_valid,
	output logic [core_pkg::xlen-1:0] retire_pc
);
	import core_pkg::*;

	typedef enum logic [1:0] {
		ls_idle,
		ls_request,
		ls_wait_rsp
	} lsu_state_e;

	lsu_state_e state;
	logic is_store;
	logic is_load;
	logic req_fire;
	logic rsp_fire;
	logic [xlen-1:0] load_data;

	assign is_store = (decoded.kind == kind_store);
	assign is_load = (decoded.kind == kind_load);

	assign dmem_req_valid = (state == ls_request);
	assign dmem_rsp_ready = (state == ls_wait_rsp);
	assign req_fire = dmem_req_valid && dmem_req_ready;
	assign rsp_fire = dmem_rsp_ready && dmem_rsp_valid;

	// word access only.
	assign dmem_req = '{addr: alu_result, wdata: rs2_data, wstrb: {4{is_store}}, write: is_store};

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= ls_idle;
			retire <= 1'b0;
			data_err <= 1'b0;
			retire_valid <= 1'b0;
		end else begin
			retire <= 1'b0;
			data_err <= rsp_fire && dmem_rsp.err;
			retire_valid <= retire;
			case (state)
				ls_idle: begin
					if (inst_valid) begin
						if (is_load || is_store)
							state <= ls_request;
						else
							retire <= 1'b1;
					end
				end
				ls_request: begin
					if (req_fire)
						state <= ls_wait_rsp;
				end
				ls_wait_rsp: begin
					if (rsp_fire) begin
						retire <= 1'b1;
						state <= ls_idle;
					end
				end
				default: state <= ls_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (rsp_fire)
			load_data <= dmem_rsp.rdata;
		if (retire)
			retire_pc <= pc; // pc still holds the retiring instruction.
	end

	assign wb_en = retire && decoded.reg_wen && !data_err;
	assign wb_rd = decoded.rd;
	assign wb_data = is_load ? load_data : alu_result;

endmodule

// ==== logic/fetch_unit.sv ====
module fetch_unit (
	input  logic clock,
	input  logic rst_n,
	output logic imem_req_valid,
	input  logic imem_req_ready,
	output core_pkg::mem_req_t imem_req,
	input  logic imem_rsp_valid,
	output logic imem_rsp_ready,
	input  core_pkg::mem_rsp_t imem_rsp,
	input  logic retire,
	input  logic [core_pkg::xlen-1:0] next_pc,
	input  logic data_err,
	output logic [core_pkg::xlen-1:0] pc,
	output logic [31:0] inst,
	output logic inst_valid
);
	import core_pkg::*;

	typedef enum logic [1:0] {
		f_idle,
		f_request,
		f_wait_rsp,
		f_execute
	} fetch_state_e;

	fetch_state_e state;
	logic req_fire;
	logic rsp_fire;

	assign imem_req_valid = (state == f_request);
	assign imem_rsp_ready = (state == f_wait_rsp);
	assign req_fire = imem_req_valid && imem_req_ready;
	assign rsp_fire = imem_rsp_ready && imem_rsp_valid;

	// read only, pc held until the request is taken.
	assign imem_req = '{addr: pc, wdata: '0, wstrb: '0, write: 1'b0};

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= f_idle;
			pc <= reset_pc;
			inst_valid <= 1'b0;
		end else begin
			inst_valid <= 1'b0;
			case (state)
				f_idle: state <= f_request;
				f_request: begin
					if (req_fire)
						state <= f_wait_rsp;
				end
				f_wait_rsp: begin
					if (rsp_fire) begin
						if (imem_rsp.err) begin
							pc <= reset_pc; // nothing retires, refetch from zero.
							state <= f_request;
						end else begin
							inst_valid <= 1'b1;
							state <= f_execute;
						end
					end
				end
				f_execute: begin
					if (retire) begin
						pc <= data_err ? reset_pc : next_pc;
						state <= f_request;
					end
				end
				default: state <= f_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (rsp_fire && !imem_rsp.err)
			inst <= imem_rsp.rdata;
	end

endmodule

// ==== logic/execute_unit.sv ====
module execute_unit (
	input  logic [core_pkg::xlen-1:0] pc,
	input  core_pkg::decoded_t decoded,
	input  logic [core_pkg::xlen-1:0] rs1_data,
	input  logic [core_pkg::xlen-1:0] rs2_data,
	output logic [core_pkg::xlen-1:0] alu_result,
	output logic [core_pkg::xlen-1:0] next_pc
);
	import core_pkg::*;

	logic [xlen-1:0] operand_b;
	logic [xlen-1:0] alu_out;
	logic [xlen-1:0] pc_plus4;
	logic [xlen-1:0] pc_plus_imm;
	logic eq;
	logic lt;

	// register operand for R-type and branch compares.
	assign operand_b = (decoded.kind == kind_alu || decoded.kind == kind_branch) ?
		rs2_data : decoded.imm;

	assign eq = (rs1_data == operand_b);
	assign lt = ($signed(rs1_data) < $signed(operand_b));
	assign pc_plus4 = pc + 32'd4;
	assign pc_plus_imm = pc + decoded.imm;

	always_comb begin
		case (decoded.alu_op)
			op_add: alu_out = rs1_data + operand_b;
			op_sub: alu_out = rs1_data - operand_b;
			op_slt: alu_out = {{(xlen-1){1'b0}}, lt};
			op_xor: alu_out = rs1_data ^ operand_b;
			op_or: alu_out = rs1_data | operand_b;
			op_and: alu_out = rs1_data & operand_b;
			op_eq: alu_out = {{(xlen-1){1'b0}}, eq};
			op_ne: alu_out = {{(xlen-1){1'b0}}, !eq};
			op_lt: alu_out = {{(xlen-1){1'b0}}, lt};
			op_ge: alu_out = {{(xlen-1){1'b0}}, !lt};
			default: alu_out = rs1_data + operand_b;
		endcase
	end

	always_comb begin
		case (decoded.kind)
			kind_lui: alu_result = decoded.imm;
			kind_auipc: alu_result = pc_plus_imm;
			kind_jal, kind_jalr: alu_result = pc_plus4; // link value.
			default: alu_result = alu_out; // includes load/store address.
		endcase
	end

	always_comb begin
		case (decoded.kind)
			kind_branch: next_pc = alu_out[0] ? pc_plus_imm : pc_plus4;
			kind_jal: next_pc = pc_plus_imm;
			kind_jalr: next_pc = {alu_out[xlen-1:1], 1'b0};
			default: next_pc = pc_plus4;
		endcase
	end

endmodule

// ==== logic/decode_unit.sv ====
module decode_unit (
	input  logic [31:0] inst,
	output core_pkg::decoded_t decoded
);
	import core_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [xlen-1:0] imm_i;
	logic [xlen-1:0] imm_s;
	logic [xlen-1:0] imm_b;
	logic [xlen-1:0] imm_u;
	logic [xlen-1:0] imm_j;
	logic writes_rd;
	alu_op_e f3_op;
	logic f3_ok;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	// funct3 map shared by op and op-imm.
	always_comb begin
		f3_ok = 1'b1;
		case (funct3)
			3'b000: f3_op = op_add;
			3'b010: f3_op = op_slt;
			3'b100: f3_op = op_xor;
			3'b110: f3_op = op_or;
			3'b111: f3_op = op_and;
			default: begin
				f3_op = op_add;
				f3_ok = 1'b0; // shifts and sltu not supported.
			end
		endcase
	end

	always_comb begin
		decoded.kind = kind_illegal;
		decoded.alu_op = op_add;
		decoded.rd = inst[10:7];
		decoded.rs1 = inst[18:15];
		decoded.rs2 = inst[23:20];
		decoded.imm = '0;
		writes_rd = 1'b0;
		case (opcode)
			7'b0110111: begin // lui.
				decoded.kind = kind_lui;
				decoded.imm = imm_u;
				writes_rd = 1'b1;
			end
			7'b0010111: begin // auipc.
				decoded.kind = kind_auipc;
				decoded.imm = imm_u;
				writes_rd = 1'b1;
			end
			7'b1101111: begin // jal.
				decoded.kind = kind_jal;
				decoded.imm = imm_j;
				writes_rd = 1'b1;
			end
			7'b1100111: begin // jalr.
				if (funct3 == 3'b000) begin
					decoded.kind = kind_jalr;
					decoded.imm = imm_i;
					writes_rd = 1'b1;
				end
			end
			7'b1100011: begin // branches.
				decoded.imm = imm_b;
				decoded.kind = kind_branch;
				case (funct3)
					3'b000: decoded.alu_op = op_eq;
					3'b001: decoded.alu_op = op_ne;
					3'b100: decoded.alu_op = op_lt;
					3'b101: decoded.alu_op = op_ge;
					default: decoded.kind = kind_illegal;
				endcase
			end
			7'b0000011: begin // lw only.
				if (funct3 == 3'b010) begin
					decoded.kind = kind_load;
					decoded.imm = imm_i;
					writes_rd = 1'b1;
				end
			end
			7'b0100011: begin // sw only.
				if (funct3 == 3'b010) begin
					decoded.kind = kind_store;
					decoded.imm = imm_s;
				end
			end
			7'b0010011: begin
				if (f3_ok) begin
					decoded.kind = kind_alu_imm;
					decoded.alu_op = f3_op;
					decoded.imm = imm_i;
					writes_rd = 1'b1;
				end
			end
			7'b0110011: begin
				if (funct7 == 7'b0000000 && f3_ok) begin
					decoded.kind = kind_alu;
					decoded.alu_op = f3_op;
					writes_rd = 1'b1;
				end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
					decoded.kind = kind_alu;
					decoded.alu_op = op_sub;
					writes_rd = 1'b1;
				end
			end
			default: decoded.kind = kind_illegal;
		endcase
		decoded.reg_wen = writes_rd && (decoded.rd != '0);
	end

endmodule

// ==== logic/register_file.sv ====
module register_file (
	input  logic clock,
	input  logic rst_n,
	input  logic [core_pkg::reg_addr_w-1:0] rs1,
	input  logic [core_pkg::reg_addr_w-1:0] rs2,
	input  logic wb_en,
	input  logic [core_pkg::reg_addr_w-1:0] wb_rd,
	input  logic [core_pkg::xlen-1:0] wb_data,
	output logic [core_pkg::xlen-1:0] rs1_data,
	output logic [core_pkg::xlen-1:0] rs2_data
);
	import core_pkg::*;

	logic [xlen-1:0] regs [0:(2**reg_addr_w)-1];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**reg_addr_w; i++)
				regs[i] <= '0;
		end else if (wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// x0 hardwired.
	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== logic/core_pkg.sv ====
package core_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 4;
	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

	typedef enum logic [3:0] {
		kind_alu,
		kind_alu_imm,
		kind_lui,
		kind_auipc,
		kind_jal,
		kind_jalr,
		kind_branch,
		kind_load,
		kind_store,
		kind_illegal
	} inst_kind_e;

	typedef enum logic [3:0] {
		op_add,
		op_sub,
		op_slt,
		op_xor,
		op_or,
		op_and,
		op_eq,
		op_ne,
		op_lt,
		op_ge
	} alu_op_e;

	typedef struct packed {
		inst_kind_e kind;
		alu_op_e alu_op;
		logic [reg_addr_w-1:0] rd;
		logic [reg_addr_w-1:0] rs1;
		logic [reg_addr_w-1:0] rs2;
		logic [xlen-1:0] imm;
		logic reg_wen;
	} decoded_t;

	typedef struct packed {
		logic [xlen-1:0] addr;
		logic [xlen-1:0] wdata;
		logic [3:0] wstrb;
		logic write;
	} mem_req_t;

	typedef struct packed {
		logic [xlen-1:0] rdata;
		logic err;
	} mem_rsp_t;

endpackage
